//--- bench/lag_max_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Bus protocol and search result checks, bound into lag_max_top
module lag_max_chk
	import lag_max_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_ack,
	input  logic        busy,
	input  logic        done,
	input  lag_result_t result,
	input  lag_cfg_t    cfg
);

	int unsigned fail_count = 0;

	////////////////////
	// Wishbone side
	ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
	else
	begin
		$error("ack held for more than one cycle");
		fail_count++;
	end

	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
	else
	begin
		$error("ack raised without a cyc and stb request");
		fail_count++;
	end

	////////////////////
	// Search side
	done_apart: assert property (@(posedge clk) disable iff (!rst_n) !(done && $rose(busy)))
	else
	begin
		$error("done pulsed while busy was rising");
		fail_count++;
	end

	// Winning lag must come from the configured range
	lag_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (result.p_max >= cfg.lag_min && result.p_max <= cfg.lag_max))
	else
	begin
		$error("best lag outside the configured lag range");
		fail_count++;
	end

endmodule

bind lag_max_top lag_max_chk chk_i (
	.clk    (clk),
	.rst_n  (rst_n),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.busy   (busy),
	.done   (done),
	.result (result),
	.cfg    (cfg)
);

`default_nettype wire

//--- bench/lag_max_tb.sv
`timescale 1ns/1ps
`include "lag_max_settings.svh"
`default_nettype none

module lag_max_tb
	import lag_max_pkg::*;
();

	localparam int depth = 2 ** `LM_ADDR_W;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`LM_WB_ADR_W-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic done;

	// Testbench copy of the sample memory
	word16_t mem_model [depth];

	logic [31:0] lcg_state = 32'h45e7;
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 400;
	int unsigned done_count = 0;
	int unsigned done_cycle = 0;
	int unsigned done_mark = 0;
	int unsigned start_cycle = 0;
	string test_name;
	int test_errors;
	int tests_passed = 0;
	int tests_failed = 0;

	lag_max_top dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.done     (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Cycle count and run limit
	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("timeout: the run went past its limit of %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// Done is a one-cycle pulse caught mid-cycle
	always @(negedge clk)
	begin
		if (rst_n && done)
		begin
			done_count = done_count + 1;
			done_cycle = cycle_cnt;
		end
	end

	////////////////////
	// Helpers
	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic int rand_below(input int n);
		logic [15:0] r;
		r = lcg_next();
		return int'(r) % n;
	endfunction

	function automatic logic [`LM_WB_ADR_W-1:0] reg_adr(input logic [`LM_REG_OFF_W-1:0] off);
		return {1'b1, {(`LM_WB_ADR_W - 1 - `LM_REG_OFF_W){1'b0}}, off};
	endfunction

	function automatic logic [`LM_WB_ADR_W-1:0] mem_adr(input int a);
		return {1'b0, mem_addr_t'(a)};
	endfunction

	function automatic int unsigned search_len(input int frame, input int lag_min,
		input int lag_max);
		return 1 + (lag_max - lag_min + 1) * (frame + 4);
	endfunction

	// Expected best correlation and lag from the basic-op rules on the memory copy
	function automatic lag_result_t ref_lag_max(input int base, input int frame,
		input int lag_min, input int lag_max);
		lag_result_t res;
		longint best;
		longint acc;
		longint prod;
		int best_lag;
		best = -64'sd2147483648;
		best_lag = 0;
		for (int t = lag_max; t >= lag_min; t--)
		begin
			acc = 0;
			for (int j = 0; j < frame; j++)
			begin
				prod = longint'(mem_model[mem_addr_t'(base + j)]) *
					longint'(mem_model[mem_addr_t'(base + j - t)]) * 2;
				if (prod > 64'sd2147483647)
					prod = 64'sd2147483647;
				acc = acc + prod;
				if (acc > 64'sd2147483647)
					acc = 64'sd2147483647;
				else if (acc < -64'sd2147483648)
					acc = -64'sd2147483648;
			end
			if (acc >= best)
			begin
				best = acc;
				best_lag = t;
			end
		end
		res.cor_max = word32_t'(best);
		res.p_max = 16'(best_lag);
		return res;
	endfunction

	////////////////////
	// Checks and test bookkeeping
	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		assert (cond)
		else
		begin
			$display("%s: %s", test_name, what);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		cycle_limit = cycle_limit + 200;
	endtask

	task automatic end_test();
		if (test_errors == 0)
		begin
			$display("test %s: ok", test_name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	////////////////////
	// Wishbone master
	task automatic wb_access(input logic we, input logic [`LM_WB_ADR_W-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		cycle_limit = cycle_limit + 4;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!wb_ack);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [`LM_WB_ADR_W-1:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [`LM_WB_ADR_W-1:0] adr, output logic [31:0] data);
		wb_access(1'b0, adr, 32'd0, data);
	endtask

	task automatic load_word(input int a, input logic [31:0] value);
		wb_write(mem_adr(a), value);
		mem_model[mem_addr_t'(a)] = value[15:0];
	endtask

	task automatic load_random(input int shift);
		logic [31:0] r;
		for (int a = 0; a < depth; a++)
		begin
			r = {lcg_next(), lcg_next()};
			r[15:0] = 16'($signed(r[15:0]) >>> shift);
			load_word(a, r);
		end
	endtask

	////////////////////
	// Search control
	task automatic set_config(input int base, input int frame, input int lag_min,
		input int lag_max);
		wb_write(reg_adr(`LM_REG_BASE), 32'(base));
		wb_write(reg_adr(`LM_REG_FRAME), 32'(frame));
		wb_write(reg_adr(`LM_REG_LAG_MIN), 32'(lag_min));
		wb_write(reg_adr(`LM_REG_LAG_MAX), 32'(lag_max));
	endtask

	task automatic start_search();
		done_mark = done_count;
		wb_write(reg_adr(`LM_REG_CTRL), 32'd1);
		start_cycle = cycle_cnt;
	endtask

	task automatic wait_for_done(input int unsigned expect_len);
		int unsigned waited;
		waited = 0;
		cycle_limit = cycle_limit + expect_len + 16;
		while (done_count == done_mark && waited < expect_len + 16)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		check_true("done never arrived", done_count != done_mark);
		check_true("done arrived later than the search length",
			done_cycle - start_cycle <= expect_len);
	endtask

	task automatic check_result(input lag_result_t expected);
		logic [31:0] value;
		wb_read(reg_adr(`LM_REG_COR), value);
		check_value("best correlation", expected.cor_max, value);
		wb_read(reg_adr(`LM_REG_LAG), value);
		check_value("best lag", {16'd0, expected.p_max}, value);
		wb_read(reg_adr(`LM_REG_STATUS), value);
		check_value("status after search", 32'd2, value);
		check_true("more than one done pulse for one start", done_count == done_mark + 1);
	endtask

	task automatic run_search(input int base, input int frame, input int lag_min,
		input int lag_max);
		lag_result_t expected;
		expected = ref_lag_max(base, frame, lag_min, lag_max);
		set_config(base, frame, lag_min, lag_max);
		start_search();
		wait_for_done(search_len(frame, lag_min, lag_max));
		check_result(expected);
	endtask

	////////////////////
	// Tests
	initial
	begin
		logic [31:0] value;
		logic [31:0] cfg_w [4];
		lag_result_t expected;
		int lag_min;
		int lag_max;
		int base;

		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		begin_test("registers after reset");
		wb_read(reg_adr(`LM_REG_STATUS), value);
		check_value("status", 32'd0, value);
		wb_read(reg_adr(`LM_REG_COR), value);
		check_value("correlation", 32'd0, value);
		wb_read(reg_adr(`LM_REG_LAG), value);
		check_value("lag", 32'd0, value);
		for (int i = 0; i < 4; i++)
		begin
			cfg_w[i] = {lcg_next(), lcg_next()};
			wb_write(reg_adr(3'(`LM_REG_BASE + i)), cfg_w[i]);
		end
		wb_read(reg_adr(`LM_REG_BASE), value);
		check_value("base readback", {24'd0, cfg_w[0][7:0]}, value);
		wb_read(reg_adr(`LM_REG_FRAME), value);
		check_value("frame readback", {16'd0, cfg_w[1][15:0]}, value);
		wb_read(reg_adr(`LM_REG_LAG_MIN), value);
		check_value("lag_min readback", {16'd0, cfg_w[2][15:0]}, value);
		wb_read(reg_adr(`LM_REG_LAG_MAX), value);
		check_value("lag_max readback", {16'd0, cfg_w[3][15:0]}, value);
		end_test();

		begin_test("memory load and readback");
		load_random(0);
		for (int a = 0; a < depth; a++)
		begin
			wb_read(mem_adr(a), value);
			check_value("sample", 32'(mem_model[mem_addr_t'(a)]), value);
		end
		end_test();

		begin_test("impulse search");
		for (int a = 0; a < depth; a++)
			load_word(a, 32'd0);
		// Pulse train with a period of 37 samples
		for (int a = 10; a < depth; a = a + 37)
			load_word(a, 32'd3000);
		load_word(200, 32'hffff_fa24);
		run_search(150, 80, 20, 120);
		end_test();

		begin_test("random frames");
		for (int k = 0; k < 4; k++)
		begin
			load_random(2);
			lag_min = 18 + rand_below(20);
			lag_max = lag_min + rand_below(60);
			base = lag_max + rand_below(depth - lag_max);
			run_search(base, 24 + rand_below(56), lag_min, lag_max);
		end
		end_test();

		begin_test("saturation and ties");
		for (int a = 0; a < depth; a++)
			load_word(a, 32'h0000_8000);
		run_search(100, 40, 30, 70);
		wb_read(reg_adr(`LM_REG_COR), value);
		check_value("saturated correlation", 32'h7fff_ffff, value);
		wb_read(reg_adr(`LM_REG_LAG), value);
		check_value("tie goes to the minimum lag", 32'd30, value);
		end_test();

		begin_test("access during search");
		load_random(2);
		expected = ref_lag_max(200, 60, 40, 90);
		set_config(200, 60, 40, 90);
		start_search();
		wb_read(reg_adr(`LM_REG_STATUS), value);
		check_value("status while busy", 32'd1, value);
		wb_write(mem_adr(210), 32'(~mem_model[8'd210]));
		wb_read(mem_adr(210), value);
		check_value("memory read while busy", 32'd0, value);
		wb_write(reg_adr(`LM_REG_CTRL), 32'd1);
		wait_for_done(search_len(60, 40, 90));
		check_result(expected);
		wb_read(mem_adr(210), value);
		check_value("sample after blocked write", 32'(mem_model[8'd210]), value);
		end_test();

		$display("tests passed %0d, failed %0d, bound assertion failures %0d",
			tests_passed, tests_failed, dut_i.chk_i.fail_count);
		if (tests_failed == 0 && dut_i.chk_i.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- lag_max_top.f
+incdir+source
source/lag_max_pkg.sv
source/scratch_mem.sv
source/frac_mac.sv
source/lag_search.sv
source/wb_host_port.sv
source/lag_max_top.sv
bench/lag_max_chk.sv
bench/lag_max_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pitch lag search testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f lag_max_top.f --top-module lag_max_tb --Mdir obj_dir

out=$(./obj_dir/Vlag_max_tb +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

//--- source/frac_mac.sv
`timescale 1ns/1ps
`default_nettype none

// L_mac style operation, sum = acc + 2*a*b with saturation
module frac_mac
	import lag_max_pkg::*;
(
	input  word32_t acc,
	input  word16_t a,
	input  word16_t b,
	output word32_t sum
);

	localparam word16_t word16_min = 16'sh8000;
	localparam word32_t word32_max = 32'sh7fff_ffff;
	localparam word32_t word32_min = 32'sh8000_0000;

	word32_t product;
	word32_t product_x2;
	logic signed [32:0] sum_wide;

	////////////////////
	// Fractional multiply
	always_comb
	begin
		product = a * b;
		// -1 * -1 is the only product that overflows Q31
		if (a == word16_min && b == word16_min)
			product_x2 = word32_max;
		else
			product_x2 = product <<< 1;
	end

	////////////////////
	// Saturating add
	always_comb
	begin
		sum_wide = {acc[31], acc} + {product_x2[31], product_x2};
		if (sum_wide[32] != sum_wide[31])
			sum = sum_wide[32] ? word32_min : word32_max;
		else
			sum = sum_wide[31:0];
	end

endmodule

`default_nettype wire

//--- source/lag_max_pkg.sv
`default_nettype none
`include "lag_max_settings.svh"

package lag_max_pkg;

	// Q15 sample and Q31 accumulator
	typedef logic signed [`LM_DATA_W-1:0] word16_t;
	typedef logic signed [`LM_ACC_W-1:0] word32_t;

	typedef logic [`LM_ADDR_W-1:0] mem_addr_t;

	// Search configuration, written by the host
	typedef struct packed {
		mem_addr_t base;
		logic [`LM_LAG_W-1:0] frame_len;
		logic [`LM_LAG_W-1:0] lag_min;
		logic [`LM_LAG_W-1:0] lag_max;
	} lag_cfg_t;

	// Best correlation and the lag it came from
	typedef struct packed {
		word32_t cor_max;
		logic [`LM_LAG_W-1:0] p_max;
	} lag_result_t;

	typedef enum logic [2:0] {
		idle,
		lag_setup,
		accumulate,
		drain,
		compare,
		finish
	} lm_state_t;

endpackage

`default_nettype wire

//--- source/lag_max_settings.svh
`ifndef LAG_MAX_SETTINGS_SVH
`define LAG_MAX_SETTINGS_SVH

// Sample memory holds 2**LM_ADDR_W words
`define LM_ADDR_W	8
`define LM_DATA_W	16
`define LM_ACC_W	32
`define LM_LAG_W	16

// Word address, top bit selects the register bank
`define LM_WB_ADR_W	9
`define LM_REG_OFF_W	3

// Register offsets inside the bank
`define LM_REG_CTRL	3'd0
`define LM_REG_STATUS	3'd1
`define LM_REG_BASE	3'd2
`define LM_REG_FRAME	3'd3
`define LM_REG_LAG_MIN	3'd4
`define LM_REG_LAG_MAX	3'd5
`define LM_REG_COR	3'd6
`define LM_REG_LAG	3'd7

`endif

//--- source/lag_max_top.sv
`timescale 1ns/1ps
`include "lag_max_settings.svh"
`default_nettype none

// Pitch lag search with a Wishbone host port
module lag_max_top
	import lag_max_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`LM_WB_ADR_W-1:0] wb_adr,
	input  logic [31:0]             wb_dat_w,
	output logic [31:0]             wb_dat_r,
	output logic                    wb_ack,
	output logic                    done
);

	lag_cfg_t cfg;
	lag_result_t result;
	logic start;
	logic busy;

	logic mem_we;
	mem_addr_t mem_waddr;
	word16_t mem_wdata;
	mem_addr_t host_raddr;
	mem_addr_t search_raddr;
	mem_addr_t mem_raddr;
	word16_t mem_rdata;
	mem_addr_t lag_raddr;
	word16_t lag_rdata;

	wb_host_port port_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.busy       (busy),
		.done       (done),
		.result     (result),
		.cfg        (cfg),
		.start      (start),
		.mem_we     (mem_we),
		.mem_waddr  (mem_waddr),
		.mem_wdata  (mem_wdata),
		.host_raddr (host_raddr),
		.mem_rdata  (mem_rdata)
	);

	// Read port follows the search while it runs
	assign mem_raddr = busy ? search_raddr : host_raddr;

	scratch_mem cur_mem_i (
		.clk   (clk),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wdata (mem_wdata),
		.raddr (mem_raddr),
		.rdata (mem_rdata)
	);

	// Mirror copy for the lagged sample, so a full pair is read per cycle
	scratch_mem lag_mem_i (
		.clk   (clk),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wdata (mem_wdata),
		.raddr (lag_raddr),
		.rdata (lag_rdata)
	);

	lag_search search_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.cfg      (cfg),
		.rd_addr  (search_raddr),
		.rd_data  (mem_rdata),
		.lag_addr (lag_raddr),
		.lag_data (lag_rdata),
		.busy     (busy),
		.done     (done),
		.result   (result)
	);

endmodule

`default_nettype wire

//--- source/lag_search.sv
`timescale 1ns/1ps
`include "lag_max_settings.svh"
`default_nettype none

// Open-loop pitch search over lags lag_max down to lag_min
module lag_search
	import lag_max_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  lag_cfg_t    cfg,
	output mem_addr_t   rd_addr,
	input  word16_t     rd_data,
	output mem_addr_t   lag_addr,
	input  word16_t     lag_data,
	output logic        busy,
	output logic        done,
	output lag_result_t result
);

	localparam word32_t cor_floor = 32'sh8000_0000;

	lm_state_t state;

	logic [`LM_LAG_W-1:0] cur_lag;
	logic [`LM_LAG_W-1:0] j_cnt;
	logic drain_last;
	logic last_lag;

	// Pipeline valid flags, one per stage
	logic rd_valid;
	logic mac_valid;

	word16_t cur_q;
	word16_t lag_q;
	word32_t acc;
	word32_t mac_sum;

	lag_result_t best_q;
	lag_result_t best_next;

	////////////////////
	// Addresses
	// x[base+j] and x[base+j-t], wrapping modulo the depth
	assign rd_addr = cfg.base + mem_addr_t'(j_cnt);
	assign lag_addr = cfg.base + mem_addr_t'(j_cnt) - mem_addr_t'(cur_lag);

	assign busy = (state != idle);
	assign done = (state == finish);
	assign last_lag = (cur_lag <= cfg.lag_min);

	////////////////////
	// MAC stage
	frac_mac mac_i (
		.acc (acc),
		.a   (cur_q),
		.b   (lag_q),
		.sum (mac_sum)
	);

	// Sample pair lands here one cycle after its address
	always_ff @(posedge clk)
	begin
		if (rd_valid)
		begin
			cur_q <= rd_data;
			lag_q <= lag_data;
		end
	end

	// Greater or equal, so a tie moves to the smaller lag
	always_comb
	begin
		best_next = best_q;
		if (acc >= best_q.cor_max)
		begin
			best_next.cor_max = acc;
			best_next.p_max = cur_lag;
		end
	end

	////////////////////
	// Control FSM
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= idle;
			cur_lag <= '0;
			j_cnt <= '0;
			drain_last <= 1'b0;
			rd_valid <= 1'b0;
			mac_valid <= 1'b0;
			acc <= '0;
			best_q <= '0;
			result <= '0;
		end
		else
		begin
			rd_valid <= (state == accumulate);
			mac_valid <= rd_valid;
			if (mac_valid)
				acc <= mac_sum;

			case (state)
				idle:
				begin
					if (start)
					begin
						cur_lag <= cfg.lag_max;
						best_q.cor_max <= cor_floor;
						best_q.p_max <= '0;
						state <= lag_setup;
					end
				end

				lag_setup:
				begin
					j_cnt <= '0;
					acc <= '0;
					drain_last <= 1'b0;
					// Empty frame skips straight to the drain
					if (cfg.frame_len == '0)
						state <= drain;
					else
						state <= accumulate;
				end

				accumulate:
				begin
					j_cnt <= j_cnt + 1'b1;
					if (j_cnt == cfg.frame_len - 1'b1)
						state <= drain;
				end

				// Two cycles, last pair goes through read then MAC
				drain:
				begin
					drain_last <= 1'b1;
					if (drain_last)
						state <= compare;
				end

				compare:
				begin
					best_q <= best_next;
					if (last_lag)
					begin
						result <= best_next;
						state <= finish;
					end
					else
					begin
						cur_lag <= cur_lag - 1'b1;
						state <= lag_setup;
					end
				end

				finish:
					state <= idle;

				default:
					state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/scratch_mem.sv
`timescale 1ns/1ps
`default_nettype none

// Sample scratch memory
// One write port, one registered read port
module scratch_mem
	import lag_max_pkg::*;
(
	input  logic      clk,
	input  logic      we,
	input  mem_addr_t waddr,
	input  word16_t   wdata,
	input  mem_addr_t raddr,
	output word16_t   rdata
);

	localparam int depth = 2 ** $bits(mem_addr_t);

	word16_t mem [depth];

	// Write side
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Read data one cycle after the address
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- source/wb_host_port.sv
`timescale 1ns/1ps
`include "lag_max_settings.svh"
`default_nettype none

// Wishbone classic slave, register bank and memory access
module wb_host_port
	import lag_max_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`LM_WB_ADR_W-1:0] wb_adr,
	input  logic [31:0]             wb_dat_w,
	output logic [31:0]             wb_dat_r,
	output logic                    wb_ack,
	input  logic                    busy,
	input  logic                    done,
	input  lag_result_t             result,
	output lag_cfg_t                cfg,
	output logic                    start,
	output logic                    mem_we,
	output mem_addr_t               mem_waddr,
	output word16_t                 mem_wdata,
	output mem_addr_t               host_raddr,
	input  word16_t                 mem_rdata
);

	logic req;
	logic sel_reg;
	logic reg_wr;
	logic [`LM_REG_OFF_W-1:0] reg_off;
	logic done_flag;
	logic [31:0] reg_rdata;

	// Captured in the request cycle, used in the ack cycle
	logic [31:0] reg_rdata_q;
	logic rd_reg_q;
	logic rd_mem_ok_q;

	////////////////////
	// Decode
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign sel_reg = wb_adr[`LM_WB_ADR_W-1];
	assign reg_off = wb_adr[`LM_REG_OFF_W-1:0];
	assign reg_wr = req && wb_we && sel_reg;

	// Memory belongs to the search while busy
	assign mem_we = req && wb_we && !sel_reg && !busy;
	assign mem_waddr = wb_adr[`LM_ADDR_W-1:0];
	assign mem_wdata = wb_dat_w[`LM_DATA_W-1:0];
	assign host_raddr = wb_adr[`LM_ADDR_W-1:0];

	////////////////////
	// Registers
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			done_flag <= 1'b0;
			cfg <= '0;
		end
		else
		begin
			wb_ack <= req;
			start <= 1'b0;
			if (done)
				done_flag <= 1'b1;
			if (reg_wr)
			begin
				case (reg_off)
					`LM_REG_CTRL:
					begin
						// A start while busy is dropped
						if (wb_dat_w[0] && !busy)
						begin
							start <= 1'b1;
							done_flag <= 1'b0;
						end
					end
					`LM_REG_BASE:    cfg.base <= wb_dat_w[`LM_ADDR_W-1:0];
					`LM_REG_FRAME:   cfg.frame_len <= wb_dat_w[`LM_LAG_W-1:0];
					`LM_REG_LAG_MIN: cfg.lag_min <= wb_dat_w[`LM_LAG_W-1:0];
					`LM_REG_LAG_MAX: cfg.lag_max <= wb_dat_w[`LM_LAG_W-1:0];
					default:         ;
				endcase
			end
		end
	end

	////////////////////
	// Read path
	always_comb
	begin
		case (reg_off)
			`LM_REG_STATUS:  reg_rdata = {30'd0, done_flag, busy};
			`LM_REG_BASE:    reg_rdata = 32'(cfg.base);
			`LM_REG_FRAME:   reg_rdata = 32'(cfg.frame_len);
			`LM_REG_LAG_MIN: reg_rdata = 32'(cfg.lag_min);
			`LM_REG_LAG_MAX: reg_rdata = 32'(cfg.lag_max);
			`LM_REG_COR:     reg_rdata = result.cor_max;
			`LM_REG_LAG:     reg_rdata = 32'(result.p_max);
			default:         reg_rdata = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (req)
		begin
			reg_rdata_q <= reg_rdata;
			rd_reg_q <= sel_reg;
			rd_mem_ok_q <= !busy;
		end
	end

	// Memory data arrives with ack, sign-extended
	assign wb_dat_r = rd_reg_q ? reg_rdata_q : (rd_mem_ok_q ? 32'(mem_rdata) : 32'd0);

endmodule

`default_nettype wire
